/* nice_vec_params.svh */
`ifndef NICE_VEC_PARAMS_SVH
`define NICE_VEC_PARAMS_SVH

// datapath and address width
`define NICE_XLEN          32

// buffer geometry
`define NICE_VEC_DEPTH     16
`define NICE_IDX_W         4
// holds counts up to and including the depth
`define NICE_CNT_W         5

// custom-3 R-type encoding
`define NICE_OPC_CUSTOM3   7'b1111011
`define NICE_F3_VEC        3'b111
`define NICE_F7_LVEC       7'd0
`define NICE_F7_LRES       7'd4
`define NICE_F7_SRES       7'd5
`define NICE_F7_MULACC     7'd6

// mulacc latency from accept to response and the byte step between words
`define NICE_MULACC_CYCLES 4
`define NICE_WORD_STEP     4

`endif

/* nice_vec_pkg.sv */
`include "nice_vec_params.svh"

package nice_vec_pkg;

	// decoded operation
	typedef enum logic [2:0]
	{
		OP_NONE,
		OP_LVEC,
		OP_LRES,
		OP_SRES,
		OP_MULACC
	} vec_op_t;

	// request from the core
	// rs1 is the base address, rs2 the word count or the scale
	typedef struct packed
	{
		logic [`NICE_XLEN-1:0] inst;
		logic [`NICE_XLEN-1:0] rs1;
		logic [`NICE_XLEN-1:0] rs2;
	} nice_req_t;

	// bus command channel payload
	typedef struct packed
	{
		logic [`NICE_XLEN-1:0] addr;
		logic                  read;
		logic [`NICE_XLEN-1:0] wdata;
	} icb_cmd_t;

	// bus response channel payload
	typedef struct packed
	{
		logic [`NICE_XLEN-1:0] rdata;
		logic                  err;
	} icb_rsp_t;

endpackage

/* nice_vec_decode.sv */
`include "nice_vec_params.svh"

module nice_vec_decode
	import nice_vec_pkg::*;
(
	input  nice_req_t req,
	output vec_op_t   op,
	output logic      illegal
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       is_vec;

	// R-type fields
	assign opcode = req.inst[6:0];
	assign funct3 = req.inst[14:12];
	assign funct7 = req.inst[31:25];

	// only custom-3 with the vector funct3 is ours
	assign is_vec = (opcode == `NICE_OPC_CUSTOM3) && (funct3 == `NICE_F3_VEC);

	always_comb
	begin
		op = OP_NONE;
		if (is_vec)
		begin
			case (funct7)
				`NICE_F7_LVEC:   op = OP_LVEC;
				`NICE_F7_LRES:   op = OP_LRES;
				`NICE_F7_SRES:   op = OP_SRES;
				`NICE_F7_MULACC: op = OP_MULACC;
				// vector 2 codes and anything else
				default:         op = OP_NONE;
			endcase
		end
	end

	// anything that did not map to an operation
	assign illegal = (op == OP_NONE);

endmodule

/* nice_vec_ctrl.sv */
`include "nice_vec_params.svh"

module nice_vec_ctrl
	import nice_vec_pkg::*;
(
	input  logic                   nice_clk,
	input  logic                   nice_rst_n,
	input  logic                   req_valid,
	input  nice_req_t              req,
	input  vec_op_t                op,
	input  logic                   illegal,
	input  logic                   rsp_ready,
	input  logic                   icb_cmd_ready,
	input  logic                   icb_rsp_valid,
	input  icb_rsp_t               icb_rsp,
	input  logic [`NICE_XLEN-1:0]  sres_wdata,
	output logic                   req_ready,
	output logic                   rsp_valid,
	output logic                   rsp_err,
	output logic                   icb_cmd_valid,
	output icb_cmd_t               icb_cmd,
	output logic                   ld_wr,
	output logic                   ld_sel_res,
	output logic [`NICE_IDX_W-1:0] ld_idx,
	output logic [`NICE_XLEN-1:0]  ld_data,
	output logic [`NICE_IDX_W-1:0] st_idx,
	output logic                   mac_fire,
	output logic [`NICE_XLEN-1:0]  mac_scale,
	output logic                   active,
	output logic                   mem_holdup
);

	typedef enum logic [2:0] {S_IDLE, S_LOAD, S_STORE, S_MAC, S_RESP} state_t;

	localparam int LAT_W = $clog2(`NICE_MULACC_CYCLES) + 1;

	state_t                 state_q;
	state_t                 state_d;
	logic [`NICE_XLEN-1:0]  base_q;
	logic [`NICE_XLEN-1:0]  arg_q;
	logic                   sel_res_q;
	logic [`NICE_CNT_W-1:0] issue_cnt_q;
	logic [`NICE_CNT_W-1:0] rsp_cnt_q;
	logic [LAT_W-1:0]       lat_cnt_q;
	logic                   err_q;
	logic [`NICE_CNT_W-1:0] count;
	logic                   req_hsk, rsp_hsk, cmd_hsk, bus_rsp_hsk;
	logic                   xfer, is_mem_op, bad_cnt, reject, last_rsp;

	////////////////////////////////////////
	// handshakes and qualifiers
	////////////////////////////////////////
	assign req_ready     = (state_q == S_IDLE);
	assign req_hsk       = req_valid & req_ready;
	assign rsp_hsk       = rsp_valid & rsp_ready;
	assign cmd_hsk       = icb_cmd_valid & icb_cmd_ready;
	assign xfer          = (state_q == S_LOAD) || (state_q == S_STORE);
	// bus responses are never stalled
	assign bus_rsp_hsk   = icb_rsp_valid & xfer;

	// count must be 1..depth for memory ops
	assign is_mem_op = (op == OP_LVEC) || (op == OP_LRES) || (op == OP_SRES);
	assign bad_cnt   = (req.rs2 == '0) || (req.rs2 > `NICE_VEC_DEPTH);
	assign reject    = illegal | (is_mem_op & bad_cnt);

	// validated count fits the narrow counter
	assign count    = arg_q[`NICE_CNT_W-1:0];
	assign last_rsp = bus_rsp_hsk && (rsp_cnt_q == count - 1'b1);

	////////////////////////////////////////
	// sequencer
	////////////////////////////////////////
	always_comb
	begin
		state_d = state_q;
		case (state_q)
			S_IDLE:
			begin
				if (req_hsk)
				begin
					if (reject)
						state_d = S_RESP;
					else if (op == OP_SRES)
						state_d = S_STORE;
					else if (op == OP_MULACC)
						state_d = S_MAC;
					else
						state_d = S_LOAD;
				end
			end
			S_LOAD, S_STORE:
			begin
				if (last_rsp)
					state_d = S_RESP;
			end
			// leave so that valid shows up the programmed cycles after accept
			S_MAC:
			begin
				if (lat_cnt_q == LAT_W'(`NICE_MULACC_CYCLES - 2))
					state_d = S_RESP;
			end
			S_RESP:
			begin
				if (rsp_ready)
					state_d = S_IDLE;
			end
			default: state_d = S_IDLE;
		endcase
	end

	always_ff @(posedge nice_clk or negedge nice_rst_n)
	begin
		if (!nice_rst_n)
		begin
			state_q     <= S_IDLE;
			base_q      <= '0;
			arg_q       <= '0;
			sel_res_q   <= 1'b0;
			issue_cnt_q <= '0;
			rsp_cnt_q   <= '0;
			lat_cnt_q   <= '0;
			err_q       <= 1'b0;
		end
		else
		begin
			state_q <= state_d;
			if (req_hsk)
			begin
				// capture operands and restart all counters
				base_q      <= req.rs1;
				arg_q       <= req.rs2;
				sel_res_q   <= (op == OP_LRES);
				issue_cnt_q <= '0;
				rsp_cnt_q   <= '0;
				lat_cnt_q   <= '0;
				err_q       <= reject;
			end
			else
			begin
				if (cmd_hsk)
					issue_cnt_q <= issue_cnt_q + 1'b1;
				if (bus_rsp_hsk)
				begin
					rsp_cnt_q <= rsp_cnt_q + 1'b1;
					err_q     <= err_q | icb_rsp.err;
				end
				if (state_q == S_MAC)
					lat_cnt_q <= lat_cnt_q + 1'b1;
				if (rsp_hsk)
					err_q <= 1'b0;
			end
		end
	end

	////////////////////////////////////////
	// bus side and buffer strobes
	////////////////////////////////////////
	// stop issuing once count commands went out
	assign icb_cmd_valid = xfer && (issue_cnt_q < count);
	assign icb_cmd.addr  = base_q + `NICE_XLEN'(issue_cnt_q) * `NICE_WORD_STEP;
	assign icb_cmd.read  = (state_q == S_LOAD);
	assign icb_cmd.wdata = sres_wdata;
	assign st_idx        = issue_cnt_q[`NICE_IDX_W-1:0];

	// read data lands in buffer slot of the response counter
	assign ld_wr      = bus_rsp_hsk & (state_q == S_LOAD);
	assign ld_sel_res = sel_res_q;
	assign ld_idx     = rsp_cnt_q[`NICE_IDX_W-1:0];
	assign ld_data    = icb_rsp.rdata;

	// update one edge ahead of the response
	assign mac_fire  = (state_q == S_MAC) && (lat_cnt_q == LAT_W'(`NICE_MULACC_CYCLES - 3));
	assign mac_scale = arg_q;

	// response and status
	assign rsp_valid  = (state_q == S_RESP);
	assign rsp_err    = err_q;
	assign active     = (state_q != S_IDLE) || req_valid;
	assign mem_holdup = xfer;

endmodule

/* nice_vec_bufs.sv */
`include "nice_vec_params.svh"

module nice_vec_bufs
(
	input  logic                   nice_clk,
	input  logic                   nice_rst_n,
	input  logic                   ld_wr,
	input  logic                   ld_sel_res,
	input  logic [`NICE_IDX_W-1:0] ld_idx,
	input  logic [`NICE_XLEN-1:0]  ld_data,
	input  logic [`NICE_IDX_W-1:0] st_idx,
	input  logic                   mac_fire,
	input  logic [`NICE_XLEN-1:0]  mac_scale,
	output logic [`NICE_XLEN-1:0]  st_data
);

	// vector A and result vector
	logic [`NICE_XLEN-1:0] vec_a   [`NICE_VEC_DEPTH];
	logic [`NICE_XLEN-1:0] vec_res [`NICE_VEC_DEPTH];
	// next result value for every lane
	logic [`NICE_XLEN-1:0] mac_sum [`NICE_VEC_DEPTH];

	////////////////////////////////////////
	// multiply-accumulate lanes
	////////////////////////////////////////
	// product and sum wrap at the word width
	always_comb
	begin
		for (int i = 0; i < `NICE_VEC_DEPTH; i++)
		begin
			mac_sum[i] = vec_res[i] + vec_a[i] * mac_scale;
		end
	end

	////////////////////////////////////////
	// storage
	////////////////////////////////////////
	// vector A only takes load writes
	always_ff @(posedge nice_clk or negedge nice_rst_n)
	begin
		if (!nice_rst_n)
		begin
			for (int i = 0; i < `NICE_VEC_DEPTH; i++)
			begin
				vec_a[i] <= '0;
			end
		end
		else if (ld_wr && !ld_sel_res)
		begin
			vec_a[ld_idx] <= ld_data;
		end
	end

	// result takes load writes or a full mulacc update
	always_ff @(posedge nice_clk or negedge nice_rst_n)
	begin
		if (!nice_rst_n)
		begin
			for (int i = 0; i < `NICE_VEC_DEPTH; i++)
			begin
				vec_res[i] <= '0;
			end
		end
		else if (mac_fire)
		begin
			for (int i = 0; i < `NICE_VEC_DEPTH; i++)
			begin
				vec_res[i] <= mac_sum[i];
			end
		end
		else if (ld_wr && ld_sel_res)
		begin
			vec_res[ld_idx] <= ld_data;
		end
	end

	// store data follows the issue index
	assign st_data = vec_res[st_idx];

endmodule

/* nice_vec_core.sv */
`include "nice_vec_params.svh"

module nice_vec_core
	import nice_vec_pkg::*;
(
	input  logic      nice_clk,
	input  logic      nice_rst_n,
	input  logic      nice_req_valid,
	output logic      nice_req_ready,
	input  nice_req_t nice_req,
	output logic      nice_rsp_valid,
	input  logic      nice_rsp_ready,
	output logic      nice_rsp_err,
	output logic      icb_cmd_valid,
	input  logic      icb_cmd_ready,
	output icb_cmd_t  icb_cmd,
	input  logic      icb_rsp_valid,
	input  icb_rsp_t  icb_rsp,
	output logic      nice_active,
	output logic      nice_mem_holdup
);

	// decoder to sequencer
	vec_op_t                op;
	logic                   illegal;

	// sequencer to buffers
	logic                   ld_wr;
	logic                   ld_sel_res;
	logic [`NICE_IDX_W-1:0] ld_idx;
	logic [`NICE_XLEN-1:0]  ld_data;
	logic [`NICE_IDX_W-1:0] st_idx;
	logic [`NICE_XLEN-1:0]  st_data;
	logic                   mac_fire;
	logic [`NICE_XLEN-1:0]  mac_scale;

	nice_vec_decode u_decode (
		.req     (nice_req),
		.op      (op),
		.illegal (illegal)
	);

	nice_vec_ctrl u_ctrl (
		.nice_clk      (nice_clk),
		.nice_rst_n    (nice_rst_n),
		.req_valid     (nice_req_valid),
		.req           (nice_req),
		.op            (op),
		.illegal       (illegal),
		.rsp_ready     (nice_rsp_ready),
		.icb_cmd_ready (icb_cmd_ready),
		.icb_rsp_valid (icb_rsp_valid),
		.icb_rsp       (icb_rsp),
		.sres_wdata    (st_data),
		.req_ready     (nice_req_ready),
		.rsp_valid     (nice_rsp_valid),
		.rsp_err       (nice_rsp_err),
		.icb_cmd_valid (icb_cmd_valid),
		.icb_cmd       (icb_cmd),
		.ld_wr         (ld_wr),
		.ld_sel_res    (ld_sel_res),
		.ld_idx        (ld_idx),
		.ld_data       (ld_data),
		.st_idx        (st_idx),
		.mac_fire      (mac_fire),
		.mac_scale     (mac_scale),
		.active        (nice_active),
		.mem_holdup    (nice_mem_holdup)
	);

	nice_vec_bufs u_bufs (
		.nice_clk   (nice_clk),
		.nice_rst_n (nice_rst_n),
		.ld_wr      (ld_wr),
		.ld_sel_res (ld_sel_res),
		.ld_idx     (ld_idx),
		.ld_data    (ld_data),
		.st_idx     (st_idx),
		.mac_fire   (mac_fire),
		.mac_scale  (mac_scale),
		.st_data    (st_data)
	);

endmodule

/* nice_vec_core_checker.sv */
`include "nice_vec_params.svh"

module nice_vec_core_checker
	import nice_vec_pkg::*;
(
	input logic     nice_clk,
	input logic     nice_rst_n,
	input logic     nice_req_ready,
	input logic     nice_rsp_valid,
	input logic     nice_rsp_ready,
	input logic     icb_cmd_valid,
	input logic     icb_cmd_ready,
	input icb_cmd_t icb_cmd
);

	timeunit 1ns;
	timeprecision 100ps;

	// count of failed assertions
	int assert_fails = 0;

	////////////////////////////////////////
	// response port
	////////////////////////////////////////
	// a raised response waits for the core
	rsp_hold: assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
		nice_rsp_valid && !nice_rsp_ready |=> nice_rsp_valid)
		else
		begin
			assert_fails++;
			$error("nice_rsp_valid dropped before nice_rsp_ready");
		end

	// no new request while a response is pending
	rsp_blocks_req: assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
		nice_rsp_valid |-> !nice_req_ready)
		else
		begin
			assert_fails++;
			$error("nice_req_ready high while nice_rsp_valid is high");
		end

	////////////////////////////////////////
	// bus command channel
	////////////////////////////////////////
	// stalled command keeps valid and all fields
	cmd_stable: assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
		icb_cmd_valid && !icb_cmd_ready |=> icb_cmd_valid && $stable(icb_cmd))
		else
		begin
			assert_fails++;
			$error("icb_cmd changed while stalled");
		end

	// commands only come from a busy sequencer
	cmd_when_busy: assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
		icb_cmd_valid |-> !nice_req_ready)
		else
		begin
			assert_fails++;
			$error("icb_cmd_valid high while nice_req_ready is high");
		end

endmodule

bind nice_vec_core nice_vec_core_checker u_checker (.*);

/* tb_nice_vec_core.sv */
`include "nice_vec_params.svh"

module tb_nice_vec_core
	import nice_vec_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [31:0] SEED      = 32'h0fa6_f8bf;
	localparam int          TIMEOUT   = 200;
	localparam int          MEM_WORDS = 1024;

	logic      nice_clk;
	logic      nice_rst_n;
	logic      nice_req_valid;
	logic      nice_req_ready;
	nice_req_t nice_req;
	logic      nice_rsp_valid;
	logic      nice_rsp_ready;
	logic      nice_rsp_err;
	logic      icb_cmd_valid;
	logic      icb_cmd_ready;
	icb_cmd_t  icb_cmd;
	logic      icb_rsp_valid;
	icb_rsp_t  icb_rsp;
	logic      nice_active;
	logic      nice_mem_holdup;

	// memory model state
	logic [31:0] mem [MEM_WORDS];
	logic [31:0] pend_data [$];
	logic        pend_err [$];
	int          pend_due [$];
	logic [31:0] log_addr [$];
	logic        log_read [$];
	logic [31:0] log_wdata [$];
	logic [31:0] mem_rng;
	logic [31:0] test_rng;
	logic [31:0] err_addr;
	logic        err_en;
	logic        holdup_seen;
	int          cycle;
	int          last_due;
	int          due;
	int          rsp_seen;
	int          errors;
	int          checks;

	nice_vec_core dut (.*);

	initial
	begin
		nice_clk = 1'b0;
		forever #2 nice_clk = ~nice_clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	// R-type word, register fields are don't care
	function automatic logic [31:0] make_inst(input logic [6:0] f7, input logic [6:0] opc);
		return {f7, 5'd2, 5'd1, `NICE_F3_VEC, 5'd3, opc};
	endfunction

	////////////////////////////////////////
	// memory model on the bus
	////////////////////////////////////////
	// decides at the falling edge, so the handshake lands on the next rising edge
	always @(negedge nice_clk)
	begin
		if (!nice_rst_n)
		begin
			icb_cmd_ready = 1'b0;
			icb_rsp_valid = 1'b0;
		end
		else
		begin
			cycle++;
			// in-order responses once their delay ran out
			icb_rsp_valid = 1'b0;
			if (pend_due.size() > 0 && pend_due[0] <= cycle)
			begin
				icb_rsp_valid = 1'b1;
				icb_rsp.rdata = pend_data.pop_front();
				icb_rsp.err   = pend_err.pop_front();
				void'(pend_due.pop_front());
				rsp_seen++;
			end
			mem_rng       = xorshift32(mem_rng);
			icb_cmd_ready = (mem_rng[1:0] != 2'b00);
			if (icb_cmd_valid && icb_cmd_ready)
			begin
				log_addr.push_back(icb_cmd.addr);
				log_read.push_back(icb_cmd.read);
				log_wdata.push_back(icb_cmd.wdata);
				if (icb_cmd.read)
					pend_data.push_back(mem[icb_cmd.addr[11:2]]);
				else
				begin
					mem[icb_cmd.addr[11:2]] = icb_cmd.wdata;
					pend_data.push_back(32'h0);
				end
				pend_err.push_back(err_en && (icb_cmd.addr == err_addr));
				// 0 to 3 extra cycles, never overtaking an older response
				due = cycle + 1 + int'(mem_rng[5:4]);
				if (due <= last_due)
					due = last_due + 1;
				last_due = due;
				pend_due.push_back(due);
			end
		end
	end

	////////////////////////////////////////
	// check and request helpers
	////////////////////////////////////////
	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			$display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	// one request, then its response; hold keeps nice_rsp_ready low after valid
	task automatic run_op(input logic [31:0] inst, input logic [31:0] rs1,
		input logic [31:0] rs2, input int hold, output int lat, output logic err);
		int n;
		log_addr.delete();
		log_read.delete();
		log_wdata.delete();
		rsp_seen = 0;
		@(negedge nice_clk);
		nice_req_valid = 1'b1;
		nice_req       = '{inst: inst, rs1: rs1, rs2: rs2};
		n = 0;
		while (!nice_req_ready && n < TIMEOUT)
		begin
			@(negedge nice_clk);
			n++;
		end
		if (!nice_req_ready)
		begin
			$display("timeout at %0t: request was never accepted", $time);
			errors++;
		end
		// accepted on the rising edge in between
		@(negedge nice_clk);
		nice_req_valid = 1'b0;
		// first cycle of the operation
		holdup_seen = nice_mem_holdup;
		lat = 1;
		while (!nice_rsp_valid && lat < TIMEOUT)
		begin
			@(negedge nice_clk);
			lat++;
		end
		if (!nice_rsp_valid)
		begin
			$display("timeout at %0t: no response to the request", $time);
			errors++;
		end
		err = nice_rsp_err;
		repeat (hold)
		begin
			@(negedge nice_clk);
			check_val("nice_rsp_valid", nice_rsp_valid, 1'b1);
			check_val("nice_req_ready", nice_req_ready, 1'b0);
			check_val("nice_active", nice_active, 1'b1);
		end
		nice_rsp_ready = 1'b1;
		@(negedge nice_clk);
		nice_rsp_ready = 1'b0;
	endtask

	// command log of one transfer against base + 4i
	task automatic check_log(input logic [31:0] base, input int n, input logic rd);
		// only memory ops raise the holdup
		check_val("nice_mem_holdup", holdup_seen, n > 0);
		check_val("command count", log_addr.size(), n);
		for (int i = 0; i < log_addr.size(); i++)
		begin
			check_val("icb_cmd.addr", log_addr[i], base + 4 * i);
			check_val("icb_cmd.read", log_read[i], rd);
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		$display("test %s done, %0d errors", name, errors - err_before);
	endtask

	////////////////////////////////////////
	// directed tests
	////////////////////////////////////////
	task automatic test_round_trip();
		logic [31:0] exp [`NICE_VEC_DEPTH];
		int          lat;
		logic        err;
		int          e0;
		e0 = errors;
		for (int i = 0; i < 8; i++)
			exp[i] = mem['h40 + i];
		run_op(make_inst(`NICE_F7_LRES, `NICE_OPC_CUSTOM3), 'h100, 8, 0, lat, err);
		check_val("nice_rsp_err", err, 1'b0);
		check_log('h100, 8, 1'b1);
		run_op(make_inst(`NICE_F7_SRES, `NICE_OPC_CUSTOM3), 'h800, 8, 0, lat, err);
		check_val("nice_rsp_err", err, 1'b0);
		check_log('h800, 8, 1'b0);
		for (int i = 0; i < log_wdata.size(); i++)
			check_val("icb_cmd.wdata", log_wdata[i], exp[i]);
		for (int i = 0; i < 8; i++)
			check_val("stored word", mem['h200 + i], exp[i]);
		report_test("round_trip", e0);
	endtask

	task automatic test_mulacc();
		logic [31:0] exp [`NICE_VEC_DEPTH];
		logic [31:0] k;
		int          lat;
		logic        err;
		int          e0;
		e0 = errors;
		test_rng = xorshift32(test_rng);
		k        = test_rng;
		// A from 0x200, R from 0x300, result goes to 0x900
		for (int i = 0; i < `NICE_VEC_DEPTH; i++)
			exp[i] = mem['hc0 + i] + mem['h80 + i] * k;
		run_op(make_inst(`NICE_F7_LVEC, `NICE_OPC_CUSTOM3), 'h200, 16, 0, lat, err);
		check_val("nice_rsp_err", err, 1'b0);
		check_log('h200, 16, 1'b1);
		run_op(make_inst(`NICE_F7_LRES, `NICE_OPC_CUSTOM3), 'h300, 16, 0, lat, err);
		check_val("nice_rsp_err", err, 1'b0);
		run_op(make_inst(`NICE_F7_MULACC, `NICE_OPC_CUSTOM3), 0, k, 0, lat, err);
		check_val("mulacc latency", lat, `NICE_MULACC_CYCLES);
		check_val("nice_rsp_err", err, 1'b0);
		check_log(0, 0, 1'b0);
		run_op(make_inst(`NICE_F7_SRES, `NICE_OPC_CUSTOM3), 'h900, 16, 0, lat, err);
		check_val("nice_rsp_err", err, 1'b0);
		check_log('h900, 16, 1'b0);
		for (int i = 0; i < `NICE_VEC_DEPTH; i++)
			check_val("mulacc word", mem['h240 + i], exp[i]);
		report_test("mulacc", e0);
	endtask

	// rejected request answers one cycle later with err and no bus traffic
	task automatic check_reject(input logic [31:0] inst, input logic [31:0] rs2);
		int   lat;
		logic err;
		run_op(inst, 'h100, rs2, 0, lat, err);
		check_val("reject latency", lat, 1);
		check_val("nice_rsp_err", err, 1'b1);
		check_log(0, 0, 1'b0);
	endtask

	task automatic test_illegal();
		int e0;
		e0 = errors;
		check_reject(make_inst(7'd9, `NICE_OPC_CUSTOM3), 4);
		// custom-0 opcode
		check_reject(make_inst(`NICE_F7_LRES, 7'b0001011), 4);
		check_reject(make_inst(`NICE_F7_LRES, `NICE_OPC_CUSTOM3), 0);
		check_reject(make_inst(`NICE_F7_SRES, `NICE_OPC_CUSTOM3), `NICE_VEC_DEPTH + 1);
		report_test("illegal", e0);
	endtask

	task automatic test_bus_err();
		int   lat;
		logic err;
		int   e0;
		e0       = errors;
		err_addr = 'h400 + 12;
		err_en   = 1'b1;
		run_op(make_inst(`NICE_F7_LVEC, `NICE_OPC_CUSTOM3), 'h400, 6, 0, lat, err);
		check_val("nice_rsp_err", err, 1'b1);
		check_val("bus responses", rsp_seen, 6);
		check_log('h400, 6, 1'b1);
		err_en = 1'b0;
		run_op(make_inst(`NICE_F7_LVEC, `NICE_OPC_CUSTOM3), 'h400, 6, 0, lat, err);
		check_val("nice_rsp_err", err, 1'b0);
		check_val("bus responses", rsp_seen, 6);
		report_test("bus_err", e0);
	endtask

	task automatic test_backpressure();
		int   lat;
		logic err;
		int   e0;
		e0 = errors;
		run_op(make_inst(`NICE_F7_LRES, `NICE_OPC_CUSTOM3), 'h100, 4, 6, lat, err);
		check_val("nice_rsp_err", err, 1'b0);
		// next request must go through once the response is taken
		run_op(make_inst(`NICE_F7_MULACC, `NICE_OPC_CUSTOM3), 0, 1, 0, lat, err);
		check_val("mulacc latency", lat, `NICE_MULACC_CYCLES);
		report_test("backpressure", e0);
	endtask

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////
	initial
	begin
		int e0;
		nice_rst_n     = 1'b0;
		nice_req_valid = 1'b0;
		nice_req       = '0;
		nice_rsp_ready = 1'b0;
		icb_cmd_ready  = 1'b0;
		icb_rsp_valid  = 1'b0;
		icb_rsp        = '0;
		mem_rng        = SEED;
		test_rng       = SEED;
		err_addr       = '0;
		err_en         = 1'b0;
		holdup_seen    = 1'b0;
		cycle          = 0;
		last_due       = 0;
		rsp_seen       = 0;
		errors         = 0;
		checks         = 0;
		// every address bit shows up in the word
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = (i * 32'h9e37_79b1) ^ {i[15:0], ~i[15:0]};
		repeat (3) @(posedge nice_clk);
		@(negedge nice_clk);
		nice_rst_n = 1'b1;
		e0 = errors;
		@(negedge nice_clk);
		check_val("nice_req_ready", nice_req_ready, 1'b1);
		check_val("nice_rsp_valid", nice_rsp_valid, 1'b0);
		check_val("icb_cmd_valid", icb_cmd_valid, 1'b0);
		check_val("nice_mem_holdup", nice_mem_holdup, 1'b0);
		report_test("reset", e0);
		test_round_trip();
		test_mulacc();
		test_illegal();
		test_bus_err();
		test_backpressure();
		// concurrent checks in the bound checker
		check_val("assertion failures", dut.u_checker.assert_fails, 0);
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* nice_vec_core.f */
+incdir+.
nice_vec_pkg.sv
nice_vec_decode.sv
nice_vec_ctrl.sv
nice_vec_bufs.sv
nice_vec_core.sv
nice_vec_core_checker.sv
tb_nice_vec_core.sv
